// ==== nnTypesPkg.sv ====
package nnTypesPkg;

	localparam int ACT_W = 8;
	localparam int WEIGHT_W = 8;
	localparam int BIAS_W = 16;
	localparam int PROD_W = ACT_W + WEIGHT_W;
	localparam int ACC_W = 23;

	typedef logic signed [ACT_W-1:0] act_t; // inputs and outputs share this format
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic signed [BIAS_W-1:0] bias_t;
	typedef logic signed [PROD_W-1:0] prod_t; // one activation times one weight
	typedef logic signed [ACC_W-1:0] acc_t;

	// output keeps 6 fraction bits fewer than the accumulator
	localparam int FRAC_SHIFT = 6;
	localparam int ROUND_BIT = 5; // half step added before the shift
	localparam act_t ACT_MAX = 8'sd127;

endpackage

// ==== nnRegPkg.sv ====
package nnRegPkg;

	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] CTRL_ADDR = 12'h000;
	localparam logic [ADDR_W-1:0] STATUS_ADDR = 12'h004;
	localparam logic [ADDR_W-1:0] INPUT_BASE = 12'h010; // one word per input
	localparam logic [ADDR_W-1:0] WEIGHT_BASE = 12'h100; // neuron major, NUM_INPUTS words each
	localparam logic [ADDR_W-1:0] BIAS_BASE = 12'h200;
	localparam logic [ADDR_W-1:0] RESULT_BASE = 12'h280; // read only

	localparam int CTRL_START_BIT = 0;
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;

	typedef enum logic [1:0]
	{
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	typedef enum logic [1:0]
	{
		IDLE,
		RUN,
		DONE
	} ctrlState_t;

endpackage

// ==== neuronLayerIf.sv ====
`timescale 1ns/1ps

interface neuronLayerIf #(
	parameter int NUM_INPUTS = 8,
	parameter int NUM_NEURONS = 4
);
	import nnTypesPkg::*;

	act_t acts [NUM_INPUTS];
	weight_t weights [NUM_NEURONS][NUM_INPUTS];
	bias_t biases [NUM_NEURONS];
	logic start; // one cycle per run
	act_t results [NUM_NEURONS];
	logic resultValid; // one cycle, results are valid with it

	modport regs (
		output acts, weights, biases, start,
		input results, resultValid
	);

	modport layer (
		input acts, weights, biases, start,
		output results, resultValid
	);

endinterface

// ==== neuron.sv ====
`timescale 1ns/1ps

module neuron #(
	parameter int NUM_INPUTS = 8
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::act_t acts [NUM_INPUTS],
	input nnTypesPkg::weight_t weights [NUM_INPUTS],
	input nnTypesPkg::bias_t bias,
	output nnTypesPkg::act_t result
);
	import nnTypesPkg::*;

	act_t actReg [NUM_INPUTS]; // stage 1
	acc_t accReg; // stage 2
	acc_t dotSum;
	prod_t prod;
	logic signed [ACC_W:0] rounded; // one spare bit for the half-step add

	always_comb
	begin
		dotSum = bias; // sign extended
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			prod = actReg[i] * weights[i];
			dotSum = dotSum + prod;
		end
	end

	always_comb
	begin
		rounded = accReg;
		rounded = (rounded + (1 << ROUND_BIT)) >>> FRAC_SHIFT; // round half up
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
			accReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= acts;
			accReg <= dotSum;
			if (accReg < 0)
				result <= '0; // relu
			else if (rounded > ACT_MAX)
				result <= ACT_MAX; // saturate
			else
				result <= act_t'(rounded);
		end
	end

endmodule

// ==== neuronLayer.sv ====
`timescale 1ns/1ps

module neuronLayer #(
	parameter int NUM_INPUTS = 8,
	parameter int NUM_NEURONS = 4
) (
	input logic clk,
	input logic reset,
	neuronLayerIf.layer lay
);
	import nnTypesPkg::*;

	// matches the register stages inside neuron
	localparam int PIPE_DEPTH = 3;

	logic [PIPE_DEPTH-1:0] validPipe;

	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gNeuron
		act_t neuronOut;

		neuron #(
			.NUM_INPUTS(NUM_INPUTS)
		) u_neuron (
			.clk(clk),
			.reset(reset),
			.acts(lay.acts), // every neuron sees the same activations
			.weights(lay.weights[n]),
			.bias(lay.biases[n]),
			.result(neuronOut)
		);

		assign lay.results[n] = neuronOut;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[PIPE_DEPTH-2:0], lay.start};
	end

	assign lay.resultValid = validPipe[PIPE_DEPTH-1];

endmodule

// ==== nnRegFile.sv ====
`timescale 1ns/1ps

module nnRegFile #(
	parameter int NUM_INPUTS = 8,
	parameter int NUM_NEURONS = 4
) (
	input logic clk,
	input logic reset,
	input logic [nnRegPkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [nnRegPkg::DATA_W-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [nnRegPkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [nnRegPkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	neuronLayerIf.regs regs
);
	import nnTypesPkg::*;
	import nnRegPkg::*;

	act_t inputRegs [NUM_INPUTS];
	weight_t weightRegs [NUM_NEURONS][NUM_INPUTS];
	bias_t biasRegs [NUM_NEURONS];
	act_t resultRegs [NUM_NEURONS];

	ctrlState_t state;
	logic startPulse;
	logic startReq;

	logic wrFire;
	logic rdFire;
	logic wrCtrl, wrInput, wrWeight, wrBias;
	int wrWord;
	int rdWord;
	resp_t wrResp;
	resp_t rdResp;
	logic [DATA_W-1:0] rdData;

	function automatic logic inRegion(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base,
		int words);
		return addr[1:0] == 2'b00 && addr >= base && addr < base + 4 * words;
	endfunction

	function automatic int wordIndex(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base);
		return (int'(addr) - int'(base)) / 4;
	endfunction

	// write decode, only CTRL, inputs, weights and biases are writable
	always_comb
	begin
		wrCtrl = awaddr == CTRL_ADDR;
		wrInput = inRegion(awaddr, INPUT_BASE, NUM_INPUTS);
		wrWeight = inRegion(awaddr, WEIGHT_BASE, NUM_NEURONS * NUM_INPUTS);
		wrBias = inRegion(awaddr, BIAS_BASE, NUM_NEURONS);
		wrResp = (wrCtrl || wrInput || wrWeight || wrBias) ? RESP_OKAY : RESP_SLVERR;
		wrWord = 0;
		if (wrInput)
			wrWord = wordIndex(awaddr, INPUT_BASE);
		else if (wrWeight)
			wrWord = wordIndex(awaddr, WEIGHT_BASE);
		else if (wrBias)
			wrWord = wordIndex(awaddr, BIAS_BASE);
	end

	assign wrFire = awvalid && awready && wvalid && wready;
	assign startReq = wrFire && wrCtrl && wdata[CTRL_START_BIT];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
		end
		else
		begin
			// both ready lines pulse for one cycle once address and data are present
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready <= awvalid && wvalid && !bvalid && !awready;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wrFire)
			begin
				bvalid <= 1'b1;
				bresp <= wrResp;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputRegs <= '{default: '0};
			weightRegs <= '{default: '0};
			biasRegs <= '{default: '0};
			resultRegs <= '{default: '0};
		end
		else
		begin
			if (wrFire && wrInput)
				inputRegs[wrWord] <= wdata[$bits(act_t)-1:0];
			if (wrFire && wrWeight)
				weightRegs[wrWord / NUM_INPUTS][wrWord % NUM_INPUTS] <= wdata[$bits(weight_t)-1:0];
			if (wrFire && wrBias)
				biasRegs[wrWord] <= wdata[$bits(bias_t)-1:0];
			if (regs.resultValid)
				resultRegs <= regs.results;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			startPulse <= 1'b0;
		end
		else
		begin
			startPulse <= 1'b0;
			case (state)
				IDLE, DONE:
					if (startReq)
					begin
						state <= RUN;
						startPulse <= 1'b1;
					end
				RUN:
					if (regs.resultValid)
						state <= DONE; // start requests are dropped while running
				default:
					state <= IDLE;
			endcase
		end
	end

	// stored fields read back zero extended; CTRL reads as zero
	always_comb
	begin
		rdData = '0;
		rdResp = RESP_OKAY;
		rdWord = 0;
		if (araddr == CTRL_ADDR)
			rdData = '0;
		else if (araddr == STATUS_ADDR)
		begin
			rdData[STATUS_DONE_BIT] = state == DONE;
			rdData[STATUS_BUSY_BIT] = state == RUN;
		end
		else if (inRegion(araddr, INPUT_BASE, NUM_INPUTS))
		begin
			rdWord = wordIndex(araddr, INPUT_BASE);
			rdData[$bits(act_t)-1:0] = inputRegs[rdWord];
		end
		else if (inRegion(araddr, WEIGHT_BASE, NUM_NEURONS * NUM_INPUTS))
		begin
			rdWord = wordIndex(araddr, WEIGHT_BASE);
			rdData[$bits(weight_t)-1:0] = weightRegs[rdWord / NUM_INPUTS][rdWord % NUM_INPUTS];
		end
		else if (inRegion(araddr, BIAS_BASE, NUM_NEURONS))
		begin
			rdWord = wordIndex(araddr, BIAS_BASE);
			rdData[$bits(bias_t)-1:0] = biasRegs[rdWord];
		end
		else if (inRegion(araddr, RESULT_BASE, NUM_NEURONS))
		begin
			rdWord = wordIndex(araddr, RESULT_BASE);
			rdData[$bits(act_t)-1:0] = resultRegs[rdWord];
		end
		else
			rdResp = RESP_SLVERR;
	end

	assign arready = !rvalid; // a pending response blocks the next read
	assign rdFire = arvalid && arready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
		end
		else if (rdFire)
		begin
			rvalid <= 1'b1;
			rdata <= rdData;
			rresp <= rdResp;
		end
		else if (rready)
			rvalid <= 1'b0;
	end

	assign regs.acts = inputRegs;
	assign regs.weights = weightRegs;
	assign regs.biases = biasRegs;
	assign regs.start = startPulse;

endmodule

// ==== nnAccelTop.sv ====
`timescale 1ns/1ps

module nnAccelTop #(
	parameter int NUM_INPUTS = 8,
	parameter int NUM_NEURONS = 4
) (
	input logic clk,
	input logic reset,
	input logic [nnRegPkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [nnRegPkg::DATA_W-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [nnRegPkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [nnRegPkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	neuronLayerIf #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) layerBus ();

	nnRegFile #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_regFile (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.regs(layerBus.regs)
	);

	neuronLayer #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_layer (
		.clk(clk),
		.reset(reset),
		.lay(layerBus.layer)
	);

endmodule

// ==== nnAccel_checker.sv ====
`timescale 1ns/1ps

module nnAccel_checker (
	input logic clk,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic start,
	input logic resultValid
);

	int assertErrors = 0; // read by the testbench at the end of the run

	bHold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else
		begin
			$error("write response changed before bready");
			assertErrors++;
		end

	rHold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else
		begin
			$error("read response changed before rready");
			assertErrors++;
		end

	startPulse: assert property (@(posedge clk) disable iff (reset) start |=> !start)
		else
		begin
			$error("start longer than one cycle");
			assertErrors++;
		end

	validDelay: assert property (@(posedge clk) disable iff (reset) start |-> ##3 resultValid)
		else
		begin
			$error("resultValid not 3 cycles after start");
			assertErrors++;
		end

endmodule

bind nnRegFile nnAccel_checker u_checker (
	.clk(clk),
	.reset(reset),
	.bvalid(bvalid),
	.bready(bready),
	.bresp(bresp),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.rresp(rresp),
	.start(regs.start),
	.resultValid(regs.resultValid)
);

// ==== nnScoreboard.sv ====
`timescale 1ns/1ps

module nnScoreboard #(
	parameter int NUM_INPUTS = 8,
	parameter int NUM_NEURONS = 4
) (
	input logic clk,
	input logic reset,
	input logic [nnRegPkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [nnRegPkg::DATA_W-1:0] wdata,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [nnRegPkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [nnRegPkg::DATA_W-1:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	output int dataErrors,
	output int respErrors
);
	import nnRegPkg::*;

	localparam int RUN_CYCLES = 4; // accept edge to the edge that latches results

	logic [DATA_W-1:0] mirror [1024]; // one entry per word address
	logic [7:0] modelResults [NUM_NEURONS];
	logic [7:0] pendingResults [NUM_NEURONS];
	ctrlState_t modelState;
	int runCycles;
	logic startSeen;
	logic wrPending;
	logic rdPending;
	logic [ADDR_W-1:0] wrAddr;
	logic [ADDR_W-1:0] rdAddr;
	logic [1:0] expBresp;
	logic [1:0] expRresp;
	logic [DATA_W-1:0] expRdata;

	// nonzero only for the writable storage words
	function automatic logic [DATA_W-1:0] storeMask(logic [ADDR_W-1:0] a);
		if (a[1:0] != 2'b00)
			return '0;
		if (a >= INPUT_BASE && a < INPUT_BASE + 4 * NUM_INPUTS)
			return 32'hFF;
		if (a >= WEIGHT_BASE && a < WEIGHT_BASE + 4 * NUM_NEURONS * NUM_INPUTS)
			return 32'hFF;
		if (a >= BIAS_BASE && a < BIAS_BASE + 4 * NUM_NEURONS)
			return 32'hFFFF;
		return '0;
	endfunction

	// relu, then round half up, drop 6 fraction bits and cap at 127
	function automatic logic [7:0] neuronModel(int n);
		int sum;
		int scaled;
		sum = int'($signed(mirror[BIAS_BASE / 4 + n][15:0]));
		for (int i = 0; i < NUM_INPUTS; i++)
			sum += $signed(mirror[INPUT_BASE / 4 + i][7:0])
				* $signed(mirror[WEIGHT_BASE / 4 + n * NUM_INPUTS + i][7:0]);
		if (sum < 0)
			return 8'd0;
		scaled = (sum + 32) >>> 6;
		if (scaled > 127)
			return 8'd127;
		return scaled[7:0];
	endfunction

	initial
	begin
		dataErrors = 0;
		respErrors = 0;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 1024; i++)
				mirror[i] = '0;
			modelResults = '{default: '0};
			modelState = IDLE;
			runCycles = 0;
			wrPending = 1'b0;
			rdPending = 1'b0;
		end
		else
		begin
			if (bvalid && bready)
			begin
				if (!wrPending)
				begin
					respErrors++;
					$display("write response arrived with no write outstanding");
				end
				else if (bresp !== expBresp)
				begin
					respErrors++;
					$display("wrong write response code for address 0x%03h", wrAddr);
				end
				wrPending = 1'b0;
			end
			if (rvalid && rready)
			begin
				if (!rdPending)
				begin
					respErrors++;
					$display("read response arrived with no read outstanding");
				end
				else
				begin
					if (rdata !== expRdata)
					begin
						dataErrors++;
						$display("ERROR rdata at 0x%03h: got 0x%08h, expected 0x%08h",
							rdAddr, rdata, expRdata);
					end
					if (rresp !== expRresp)
					begin
						respErrors++;
						$display("wrong read response code for address 0x%03h", rdAddr);
					end
				end
				rdPending = 1'b0;
			end
			if (arvalid && arready)
			begin
				if (rdPending)
				begin
					respErrors++;
					$display("read accepted while the previous read response was pending");
				end
				rdPending = 1'b1;
				rdAddr = araddr;
				expRresp = RESP_OKAY;
				expRdata = '0;
				if (araddr == STATUS_ADDR)
					expRdata = {30'b0, modelState == RUN, modelState == DONE};
				else if (storeMask(araddr) != 0)
					expRdata = mirror[araddr[11:2]];
				else if (araddr[1:0] == 2'b00 && araddr >= RESULT_BASE
					&& araddr < RESULT_BASE + 4 * NUM_NEURONS)
					expRdata = {24'b0, modelResults[int'((araddr - RESULT_BASE) >> 2)]};
				else if (araddr != CTRL_ADDR)
					expRresp = RESP_SLVERR; // unmapped or unaligned
			end
			startSeen = 1'b0;
			if (awvalid && awready && wvalid && wready)
			begin
				if (wrPending)
				begin
					respErrors++;
					$display("write accepted while the previous write response was pending");
				end
				wrPending = 1'b1;
				wrAddr = awaddr;
				expBresp = (awaddr == CTRL_ADDR || storeMask(awaddr) != 0) ? RESP_OKAY
					: RESP_SLVERR;
				if (storeMask(awaddr) != 0)
					mirror[awaddr[11:2]] = wdata & storeMask(awaddr);
				startSeen = awaddr == CTRL_ADDR && wdata[0];
			end
			if (modelState == RUN)
			begin
				runCycles++; // starts during a run are dropped
				if (runCycles == RUN_CYCLES)
				begin
					modelState = DONE;
					modelResults = pendingResults;
				end
			end
			else if (startSeen)
			begin
				for (int n = 0; n < NUM_NEURONS; n++)
					pendingResults[n] = neuronModel(n);
				modelState = RUN;
				runCycles = 0;
			end
		end
	end

endmodule

// ==== nnAccelTb.sv ====
`timescale 1ns/1ps

module nnAccelTb;
	import nnRegPkg::*;

	localparam int NUM_INPUTS = 8;
	localparam int NUM_NEURONS = 4;
	localparam int WEIGHT_WORDS = NUM_NEURONS * NUM_INPUTS;
	localparam int REG_WORDS = NUM_INPUTS + WEIGHT_WORDS + NUM_NEURONS;
	// readback, random runs, edge runs, error cases, busy run, plus polling slack
	localparam int PLANNED_TXNS = 7 * REG_WORDS + 80;
	localparam int WATCHDOG_CYCLES = PLANNED_TXNS * 40;

	logic clk = 1'b0;
	logic reset;
	logic [ADDR_W-1:0] awaddr;
	logic [ADDR_W-1:0] araddr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic awvalid, awready, wvalid, wready;
	logic bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp;
	logic [1:0] rresp;
	int dataErrors;
	int respErrors;
	int assertErrors;
	int maxStall = 3; // longest bready or rready hold-off
	logic [31:0] lcgState = 32'd41;
	logic [31:0] rdValue;
	int edgeBias [4] = '{-100, 32, 96, 31}; // zero, half step, half step, just below

	always #4 clk = ~clk;

	nnAccelTop #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_nnAccelTop (.*);

	nnScoreboard #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_scoreboard (.*);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {lcgState[15:0], lcgState[31:16]}; // high bits are the better ones
	endfunction

	// inputs, then weights, then biases
	function automatic logic [ADDR_W-1:0] regAddr(int k);
		if (k < NUM_INPUTS)
			return ADDR_W'(INPUT_BASE + 4 * k);
		if (k < NUM_INPUTS + WEIGHT_WORDS)
			return ADDR_W'(WEIGHT_BASE + 4 * (k - NUM_INPUTS));
		return ADDR_W'(BIAS_BASE + 4 * (k - NUM_INPUTS - WEIGHT_WORDS));
	endfunction

	task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int stall;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		stall = nextRand() % (maxStall + 1);
		repeat (stall) @(posedge clk);
		bready <= 1'b1;
		do
			@(posedge clk);
		while (!bvalid);
		bready <= 1'b0;
	endtask

	task automatic readReg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		int stall;
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		stall = nextRand() % (maxStall + 1);
		repeat (stall) @(posedge clk);
		rready <= 1'b1;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic loadRandomRegs();
		for (int k = 0; k < REG_WORDS; k++)
			writeReg(regAddr(k), nextRand());
	endtask

	task automatic readBackAll();
		for (int k = 0; k < REG_WORDS; k++)
			readReg(regAddr(k), rdValue);
	endtask

	task automatic runLayer();
		logic [DATA_W-1:0] status;
		writeReg(CTRL_ADDR, 32'h1);
		do
			readReg(STATUS_ADDR, status);
		while (!status[0]);
		for (int n = 0; n < NUM_NEURONS; n++)
			readReg(ADDR_W'(RESULT_BASE + 4 * n), rdValue);
	endtask

	initial
	begin
		reset = 1'b1;
		awaddr = '0;
		wdata = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		loadRandomRegs();
		readBackAll();
		repeat (2)
		begin
			loadRandomRegs();
			runLayer();
		end

		for (int k = 0; k < REG_WORDS; k++)
			writeReg(regAddr(k), (k < NUM_INPUTS + WEIGHT_WORDS) ? 32'd127 : 32'd0); // saturate
		runLayer();
		for (int i = 0; i < NUM_INPUTS; i++)
			writeReg(regAddr(i), 32'd0);
		for (int n = 0; n < NUM_NEURONS; n++)
			writeReg(ADDR_W'(BIAS_BASE + 4 * n), edgeBias[n % 4]);
		runLayer();

		writeReg(RESULT_BASE, 32'h55); // read only
		writeReg(12'h3F0, 32'h66);
		writeReg(INPUT_BASE + 12'h2, 32'h77); // unaligned
		readReg(12'h3F0, rdValue);
		readReg(12'h008, rdValue);
		readReg(INPUT_BASE + 12'h2, rdValue);
		readBackAll();

		loadRandomRegs();
		maxStall = 0; // second start must land inside the run
		writeReg(CTRL_ADDR, 32'h1);
		runLayer();
		maxStall = 3;
		readReg(STATUS_ADDR, rdValue);

		assertErrors = u_nnAccelTop.u_regFile.u_checker.assertErrors;
		$display("errors: %0d data, %0d response, %0d assertion",
			dataErrors, respErrors, assertErrors);
		if (dataErrors + respErrors + assertErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
nnTypesPkg.sv
nnRegPkg.sv
neuronLayerIf.sv
neuron.sv
neuronLayer.sv
nnRegFile.sv
nnAccelTop.sv
nnAccel_checker.sv
nnScoreboard.sv
nnAccelTb.sv
